// ==== Makefile ====
# Verilator simulation of the control decoder

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
		--top-module controlBlockTb -Mdir obj_dir
	./obj_dir/VcontrolBlockTb | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/ctrlModel.svh ====
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// flags are {invA, invB, cin, sign}
function automatic exCtrlT execute(input aluOpT op, input aluSrcT src, input logic [3:0] flags);
    exCtrlT e;
    e.aluOp  = op;
    e.aluSrc = src;
    {e.invA, e.invB, e.cin, e.sign} = flags;
    return e;
endfunction

// register write without memory access
function automatic memWbCtrlT writeBack(input regDstT dst, input wrtSrcT src);
    memWbCtrlT m;
    m           = '0;
    m.regWrt    = 1'b1;
    m.regDst    = dst;
    m.regWrtSrc = src;
    return m;
endfunction

function automatic ctrlWordT expectCtrl(input logic [`OPCODE_W-1:0] op,
                                        input logic [`FUNC_W-1:0] fn);
    ctrlWordT w;
    w = '0;
    case (op)
        OP_HALT: w.flow.halt = 1'b1;
        OP_NOP: w = '0;
        OP_SIIC, OP_RTI: w.err = 1'b1;
        OP_J, OP_JAL, OP_JR, OP_JALR: begin
            w.ex        = execute(ROL, SRC_REG, 4'b0000);
            w.flow.jump = 1'b1;
            // J and JAL are pc relative while JR and JALR go through a register
            w.flow.pcOffSel = (op == OP_J) || (op == OP_JAL);
            w.flow.ret      = (op == OP_JR) || (op == OP_JALR);
            if (op == OP_JAL || op == OP_JALR)
                w.memWb = writeBack(DST_R7, WS_PC);
        end
        OP_ADDI, OP_SUBI: begin
            w.ex    = execute(ADD, SRC_IMM5S, (op == OP_SUBI) ? 4'b1011 : 4'b0001);
            w.memWb = writeBack(DST_I1, WS_ALU);
        end
        OP_XORI, OP_ANDNI: begin
            w.ex    = execute((op == OP_XORI) ? XOR : ANDN, SRC_IMM5Z,
                              (op == OP_ANDNI) ? 4'b0100 : 4'b0000);
            w.memWb = writeBack(DST_I1, WS_ALU);
        end
        OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
            // low opcode bits order the shifts like the R-format func
            w.ex    = execute(aluOpT'({1'b0, op[1:0]}), SRC_IMM5Z, 4'b0000);
            w.memWb = writeBack(DST_I1, WS_ALU);
        end
        OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            w.ex          = execute(ADD, SRC_ZERO, 4'b0001);
            w.flow.brType = brTypeT'({1'b0, op[1:0]} + 3'd1);
        end
        OP_ST: begin
            w.ex           = execute(ADD, SRC_IMM5S, 4'b0000);
            w.memWb.memEn  = 1'b1;
            w.memWb.memWrt = 1'b1;
        end
        OP_LD: begin
            w.ex          = execute(ADD, SRC_IMM5S, 4'b0000);
            w.memWb       = writeBack(DST_I1, WS_MEM);
            w.memWb.memEn = 1'b1;
        end
        OP_STU: begin
            w.ex           = execute(ADD, SRC_IMM5S, 4'b0001);
            w.memWb        = writeBack(DST_I2, WS_ALU);
            w.memWb.memEn  = 1'b1;
            w.memWb.memWrt = 1'b1;
        end
        OP_LBI, OP_SLBI: begin
            w.ex    = execute(ROL, SRC_REG, 4'b0000);
            w.memWb = writeBack(DST_I2, (op == OP_LBI) ? WS_IMM8 : WS_SLBI);
        end
        OP_BTR: begin
            w.ex    = execute(ADD, SRC_REG, 4'b0000);
            w.memWb = writeBack(DST_R, WS_BTR);
        end
        OP_ALU_OP1: begin
            case (fn)
                2'd0:    w.ex = execute(ADD, SRC_REG, 4'b0001);
                2'd1:    w.ex = execute(ADD, SRC_REG, 4'b1011);
                2'd2:    w.ex = execute(XOR, SRC_REG, 4'b0000);
                default: w.ex = execute(ANDN, SRC_REG, 4'b0100);
            endcase
            w.memWb = writeBack(DST_R, WS_ALU);
        end
        OP_ALU_OP2: begin
            w.ex    = execute(aluOpT'({1'b0, fn}), SRC_REG, 4'b0000);
            w.memWb = writeBack(DST_R, WS_ALU);
        end
        OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
            w.ex    = execute(ADD, SRC_REG, 4'b0000);
            w.memWb = writeBack(DST_R, WS_COND);
        end
        default: w.err = 1'b1;
    endcase
    return w;
endfunction

`endif

// ==== bench/controlBlockTb.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module controlBlockTb;
    import decodePkg::*;

    `include "ctrlModel.svh"

    localparam int RESET_CYCLES  = 8;
    localparam int SWEEP_CYCLES  = 128;
    localparam int RANDOM_CYCLES = 600;
    // all phases plus margin for idle and drain cycles
    localparam int CYCLE_LIMIT = RESET_CYCLES + SWEEP_CYCLES + RANDOM_CYCLES + 264;

    logic                 clk;
    logic                 arstN;
    logic                 instrValid;
    logic [`OPCODE_W-1:0] opCode;
    logic [`FUNC_W-1:0]   func;
    logic                 ctrlValid;
    ctrlWordT             ctrl;

    logic        expValid;
    ctrlWordT    expWord;
    logic [31:0] lfsrState;
    logic [31:0] bits;
    int          mismatchCount = 0;
    int          failCount = 0;
    int          checkCount = 0;
    int          issueCount = 0;
    int          resultCount = 0;
    int          errSeen = 0;
    int          cycleCount = 0;

    controlBlock i_dut (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .opCode     (opCode),
        .func       (func),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] r);
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
    endtask

    task automatic printSummary();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checkCount, mismatchCount, failCount);
    endtask

    // outputs seen here still hold the previous cycle's result
    always @(posedge clk) begin
        if (!arstN) begin
            assert (ctrlValid === 1'b0 && ctrl === '0) else begin
                mismatchCount++;
                $display("mismatch at %0t: not cleared in reset, ctrlValid=%b ctrl=%h",
                         $time, ctrlValid, ctrl);
            end
            expValid = 1'b0;
            expWord  = '0;
        end else begin
            checkCount++;
            assert (ctrlValid === expValid) else begin
                mismatchCount++;
                $display("mismatch at %0t: ctrlValid expected %b, got %b",
                         $time, expValid, ctrlValid);
            end
            assert (ctrl === expWord) else begin
                mismatchCount++;
                $display("mismatch at %0t: ctrl expected %h, got %h", $time, expWord, ctrl);
            end
            if (ctrlValid === 1'b1) begin
                resultCount++;
                if (ctrl.err) begin
                    errSeen++;
                    // illegal instruction must not touch state or flow
                    assert (!(ctrl.memWb.regWrt || ctrl.memWb.memWrt || ctrl.memWb.memEn
                              || ctrl.flow.jump || ctrl.flow.halt)) else begin
                        mismatchCount++;
                        $display("mismatch at %0t: illegal word has active controls %h",
                                 $time, ctrl);
                    end
                end
            end
            expValid = instrValid;
            if (instrValid)
                expWord = expectCtrl(opCode, func);
        end
    end

    initial begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        opCode     = '0;
        func       = '0;
        lfsrState  = 32'h6ad3_0407;
        repeat (RESET_CYCLES) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        // every opcode and func pair back to back
        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            instrValid = 1'b1;
            {opCode, func} = i[6:0];
            issueCount++;
            @(negedge clk);
        end

        // random stream with roughly one gap in four
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            drawBits(2, bits);
            instrValid = (bits[1:0] != 2'b00);
            drawBits(7, bits);
            {opCode, func} = bits[6:0];
            if (instrValid)
                issueCount++;
            @(negedge clk);
        end
        instrValid = 1'b0;
        repeat (3) @(negedge clk);

        assert (resultCount == issueCount) else begin
            failCount++;
            $display("valid results (%0d) differ from issued instructions (%0d)",
                     resultCount, issueCount);
        end
        assert (errSeen >= 8) else begin
            failCount++;
            $display("too few illegal instructions reached the output: %0d", errSeen);
        end

        printSummary();
        if (mismatchCount == 0 && failCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycleCount);
        printSummary();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
+incdir+bench
src/decodePkg.sv
src/opClassify.sv
src/aluDecode.sv
src/memWbDecode.sv
src/flowDecode.sv
src/decodeStage.sv
src/controlBlock.sv
bench/controlBlockTb.sv

// ==== src/aluDecode.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module aluDecode (
    input  decodePkg::formatT     format,
    input  decodePkg::opCodeT     opCode,
    input  logic [`FUNC_W-1:0]    func,
    output decodePkg::exCtrlT     ex
);
    import decodePkg::*;

    logic rAdd;
    logic rSub;
    logic rAndn;

    // func only matters for the two R-format ALU opcodes
    assign rAdd  = (format == FMT_R) && (opCode == OP_ALU_OP1) && (func == 2'd0);
    assign rSub  = (format == FMT_R) && (opCode == OP_ALU_OP1) && (func == 2'd1);
    assign rAndn = (format == FMT_R) && (opCode == OP_ALU_OP1) && (func == 2'd3);

    always_comb begin
        ex = '0;
        if (format != FMT_SPECIAL && format != FMT_ILLEGAL) begin
            case (opCode)
                OP_ALU_OP1: begin
                    case (func)
                        2'd2:    ex.aluOp = XOR;
                        2'd3:    ex.aluOp = ANDN;
                        default: ex.aluOp = ADD;
                    endcase
                end
                OP_ALU_OP2: begin
                    case (func)
                        2'd0:    ex.aluOp = ROL;
                        2'd1:    ex.aluOp = SLL;
                        2'd2:    ex.aluOp = ROR;
                        default: ex.aluOp = SRL;
                    endcase
                end
                OP_XORI:  ex.aluOp = XOR;
                OP_ANDNI: ex.aluOp = ANDN;
                OP_ROLI:  ex.aluOp = ROL;
                OP_SLLI:  ex.aluOp = SLL;
                OP_RORI:  ex.aluOp = ROR;
                OP_SRLI:  ex.aluOp = SRL;
                OP_ADDI, OP_SUBI, OP_ST, OP_LD, OP_STU, OP_BTR,
                OP_SEQ, OP_SLT, OP_SLE, OP_SCO,
                OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ:
                    ex.aluOp = ADD;
                // jumps and immediate loads bypass the alu
                default:  ex.aluOp = ROL;
            endcase

            case (opCode)
                OP_ADDI, OP_SUBI, OP_ST, OP_LD, OP_STU:
                    ex.aluSrc = SRC_IMM5S;
                OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI:
                    ex.aluSrc = SRC_IMM5Z;
                OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ:
                    ex.aluSrc = SRC_ZERO;
                default:
                    ex.aluSrc = SRC_REG;
            endcase

            ex.invA = rSub || (opCode == OP_SUBI);
            ex.cin  = rSub || (opCode == OP_SUBI);
            ex.invB = rAndn || (opCode == OP_ANDNI);
            ex.sign = rAdd || rSub
                      || (opCode inside {OP_ADDI, OP_SUBI, OP_STU})
                      || (opCode inside {OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ});
        end
    end

endmodule

// ==== src/controlBlock.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module controlBlock (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  instrValid,
    input  logic [`OPCODE_W-1:0]  opCode,
    input  logic [`FUNC_W-1:0]    func,
    output logic                  ctrlValid,
    output decodePkg::ctrlWordT   ctrl
);
    import decodePkg::*;

    opCodeT    opCodeTyped;
    formatT    format;
    logic      err;
    exCtrlT    ex;
    memWbCtrlT memWb;
    flowCtrlT  flow;

    assign opCodeTyped = opCodeT'(opCode);

    opClassify i_opClassify (
        .opCode (opCodeTyped),
        .format (format),
        .err    (err)
    );

    aluDecode i_aluDecode (
        .format (format),
        .opCode (opCodeTyped),
        .func   (func),
        .ex     (ex)
    );

    memWbDecode i_memWbDecode (
        .format (format),
        .opCode (opCodeTyped),
        .memWb  (memWb)
    );

    flowDecode i_flowDecode (
        .format (format),
        .opCode (opCodeTyped),
        .flow   (flow)
    );

    decodeStage i_decodeStage (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .ex         (ex),
        .memWb      (memWb),
        .flow       (flow),
        .err        (err),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

endmodule

// ==== src/ctrl_defines.svh ====
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// instruction fields
`define OPCODE_W 5
`define FUNC_W 2

// alu operation code
`define ALUOP_W 3

`endif

// ==== src/decodePkg.sv ====
`include "ctrl_defines.svh"

package decodePkg;

    typedef enum logic [`OPCODE_W-1:0] {
        OP_HALT    = 5'b00000,
        OP_NOP     = 5'b00001,
        OP_SIIC    = 5'b00010,
        OP_RTI     = 5'b00011,
        OP_J       = 5'b00100,
        OP_JR      = 5'b00101,
        OP_JAL     = 5'b00110,
        OP_JALR    = 5'b00111,
        OP_ADDI    = 5'b01000,
        OP_SUBI    = 5'b01001,
        OP_XORI    = 5'b01010,
        OP_ANDNI   = 5'b01011,
        OP_BEQZ    = 5'b01100,
        OP_BNEZ    = 5'b01101,
        OP_BLTZ    = 5'b01110,
        OP_BGEZ    = 5'b01111,
        OP_ST      = 5'b10000,
        OP_LD      = 5'b10001,
        OP_SLBI    = 5'b10010,
        OP_STU     = 5'b10011,
        OP_ROLI    = 5'b10100,
        OP_SLLI    = 5'b10101,
        OP_RORI    = 5'b10110,
        OP_SRLI    = 5'b10111,
        OP_LBI     = 5'b11000,
        OP_BTR     = 5'b11001,
        OP_ALU_OP2 = 5'b11010,
        OP_ALU_OP1 = 5'b11011,
        OP_SEQ     = 5'b11100,
        OP_SLT     = 5'b11101,
        OP_SLE     = 5'b11110,
        OP_SCO     = 5'b11111
    } opCodeT;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I1,
        FMT_I2,
        FMT_J,
        FMT_SPECIAL,
        FMT_ILLEGAL
    } formatT;

    // subtract is ADD with invA and cin
    typedef enum logic [`ALUOP_W-1:0] {
        ROL  = 3'd0,
        SLL  = 3'd1,
        ROR  = 3'd2,
        SRL  = 3'd3,
        ADD  = 3'd4,
        XOR  = 3'd6,
        ANDN = 3'd7
    } aluOpT;

    typedef enum logic [2:0] {
        SRC_IMM5S = 3'd0,
        SRC_IMM5Z = 3'd1,
        SRC_REG   = 3'd4,
        SRC_ZERO  = 3'd5
    } aluSrcT;

    typedef enum logic [1:0] {
        DST_I1 = 2'd0,
        DST_I2 = 2'd1,
        DST_R  = 2'd2,
        DST_R7 = 2'd3
    } regDstT;

    typedef enum logic [2:0] {
        WS_MEM  = 3'd0,
        WS_ALU  = 3'd1,
        WS_PC   = 3'd2,
        WS_COND = 3'd3,
        WS_IMM8 = 3'd4,
        WS_SLBI = 3'd5,
        WS_BTR  = 3'd6
    } wrtSrcT;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQZ  = 3'd1,
        BR_NEZ  = 3'd2,
        BR_LTZ  = 3'd3,
        BR_GEZ  = 3'd4
    } brTypeT;

    typedef struct packed {
        aluOpT  aluOp;
        aluSrcT aluSrc;
        logic   invA;
        logic   invB;
        logic   cin;
        logic   sign;
    } exCtrlT;

    typedef struct packed {
        logic   memEn;
        logic   memWrt;
        logic   regWrt;
        regDstT regDst;
        wrtSrcT regWrtSrc;
    } memWbCtrlT;

    typedef struct packed {
        logic   jump;
        logic   ret;
        logic   pcOffSel;
        brTypeT brType;
        logic   halt;
    } flowCtrlT;

    typedef struct packed {
        exCtrlT    ex;
        memWbCtrlT memWb;
        flowCtrlT  flow;
        logic      err;
    } ctrlWordT;

endpackage

// ==== src/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    input  decodePkg::exCtrlT    ex,
    input  decodePkg::memWbCtrlT memWb,
    input  decodePkg::flowCtrlT  flow,
    input  logic                 err,
    output logic                 ctrlValid,
    output decodePkg::ctrlWordT  ctrl
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlValid <= 1'b0;
            ctrl      <= '0;
        end else begin
            ctrlValid <= instrValid;
            // hold last word through gaps
            if (instrValid) begin
                ctrl <= '{ex: ex, memWb: memWb, flow: flow, err: err};
            end
        end
    end

endmodule

// ==== src/flowDecode.sv ====
`timescale 1ns/1ps

module flowDecode (
    input  decodePkg::formatT   format,
    input  decodePkg::opCodeT   opCode,
    output decodePkg::flowCtrlT flow
);
    import decodePkg::*;

    always_comb begin
        flow = '0;
        case (format)
            // pc-relative jumps
            FMT_J: begin
                flow.jump     = 1'b1;
                flow.pcOffSel = 1'b1;
            end
            FMT_I2: begin
                case (opCode)
                    OP_JR, OP_JALR: begin
                        flow.jump = 1'b1;
                        flow.ret  = 1'b1;
                    end
                    OP_BEQZ: flow.brType = BR_EQZ;
                    OP_BNEZ: flow.brType = BR_NEZ;
                    OP_BLTZ: flow.brType = BR_LTZ;
                    OP_BGEZ: flow.brType = BR_GEZ;
                    default: flow.brType = BR_NONE;
                endcase
            end
            FMT_SPECIAL: flow.halt = (opCode == OP_HALT);
            default: flow = '0;
        endcase
    end

endmodule

// ==== src/memWbDecode.sv ====
`timescale 1ns/1ps

module memWbDecode (
    input  decodePkg::formatT    format,
    input  decodePkg::opCodeT    opCode,
    output decodePkg::memWbCtrlT memWb
);
    import decodePkg::*;

    always_comb begin
        memWb = '0;
        memWb.memEn  = (opCode inside {OP_ST, OP_LD, OP_STU});
        memWb.memWrt = (opCode inside {OP_ST, OP_STU});
        memWb.regWrt = (format == FMT_R)
                       || ((format == FMT_I1) && (opCode != OP_ST))
                       || (opCode inside {OP_LBI, OP_SLBI, OP_JAL, OP_JALR});

        case (format)
            FMT_R:  memWb.regDst = DST_R;
            // stu writes back the updated base
            FMT_I1: memWb.regDst = (opCode == OP_STU) ? DST_I2 : DST_I1;
            FMT_I2, FMT_J: begin
                if (opCode inside {OP_LBI, OP_SLBI})
                    memWb.regDst = DST_I2;
                else if (opCode inside {OP_JAL, OP_JALR})
                    memWb.regDst = DST_R7;
            end
            default: memWb.regDst = DST_I1;
        endcase

        if (memWb.regWrt) begin
            case (opCode)
                OP_LD:                          memWb.regWrtSrc = WS_MEM;
                OP_SEQ, OP_SLT, OP_SLE, OP_SCO: memWb.regWrtSrc = WS_COND;
                OP_BTR:                         memWb.regWrtSrc = WS_BTR;
                OP_JAL, OP_JALR:                memWb.regWrtSrc = WS_PC;
                OP_LBI:                         memWb.regWrtSrc = WS_IMM8;
                OP_SLBI:                        memWb.regWrtSrc = WS_SLBI;
                default:                        memWb.regWrtSrc = WS_ALU;
            endcase
        end
    end

endmodule

// ==== src/opClassify.sv ====
`timescale 1ns/1ps

module opClassify (
    input  decodePkg::opCodeT opCode,
    output decodePkg::formatT format,
    output logic              err
);
    import decodePkg::*;

    always_comb begin
        case (opCode)
            OP_BTR, OP_ALU_OP1, OP_ALU_OP2,
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO:
                format = FMT_R;
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI,
            OP_ST, OP_LD, OP_STU:
                format = FMT_I1;
            OP_LBI, OP_SLBI, OP_JR, OP_JALR,
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ:
                format = FMT_I2;
            OP_J, OP_JAL:
                format = FMT_J;
            OP_HALT, OP_NOP:
                format = FMT_SPECIAL;
            // no exception support
            default:
                format = FMT_ILLEGAL;
        endcase
    end

    assign err = (format == FMT_ILLEGAL);

endmodule
